/* source/game_pkg.sv */
`default_nettype none

package game_pkg;

    // game flow as seen by both players
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        CONNECT   = 3'd1,
        KEEPER    = 3'd2,
        SHOOTER   = 3'd3,
        MATCH_END = 3'd4
    } g_state;

    localparam int GAME_VAL_W = 8;

    // keeper position, shot position and score share one width
    typedef logic [GAME_VAL_W-1:0] game_val_t;

endpackage

`default_nettype wire

/* source/link_pkg.sv */
`default_nettype none

package link_pkg;

    localparam int BYTE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;

    // first byte of every message, value byte follows
    typedef enum logic [BYTE_W-1:0] {
        TAG_STATE  = 8'hA1,
        TAG_KEEPER = 8'hA2,
        TAG_SHOT   = 8'hA3,
        TAG_SCORE  = 8'hA4
    } msg_tag_e;

    // one received frame, data plus stop bit status
    typedef struct packed {
        byte_t data;
        logic  frame_err;   // stop bit read as 0
    } rx_byte_t;

    function automatic logic is_known_tag(input byte_t b);
        case (b)
            TAG_STATE,
            TAG_KEEPER,
            TAG_SHOT,
            TAG_SCORE: is_known_tag = 1'b1;
            default:   is_known_tag = 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

/* source/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int  FIFO_DEPTH = 16,
    parameter type item_t     = logic [7:0]
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wr_en,
    input  item_t wr_data,
    input  logic  rd_en,
    output item_t rd_data,
    output logic  full,
    output logic  empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    item_t       mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;    // msb is the wrap bit
    logic [AW:0] rd_ptr;
    logic        wr_ok;
    logic        rd_ok;

    assign empty = (wr_ptr == rd_ptr);
    // same slot, different lap
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
        if (rd_ok) begin
            rd_data <= mem[rd_ptr[AW-1:0]];  // valid one cycle after rd_en
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/msg_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_encoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                state_send,
    input  game_pkg::g_state    state_value,
    input  logic                keeper_send,
    input  game_pkg::game_val_t keeper_value,
    input  logic                shot_send,
    input  game_pkg::game_val_t shot_value,
    input  logic                score_send,
    input  game_pkg::game_val_t score_value,
    input  logic                full,
    output logic                wr_en,
    output link_pkg::byte_t     wr_data
);

    import game_pkg::*;
    import link_pkg::*;

    localparam int NUM_SRC = 4;

    typedef enum logic {S_TAG, S_VALUE} enc_phase_e;

    enc_phase_e         phase;
    logic [NUM_SRC-1:0] send_req;
    logic [NUM_SRC-1:0] pending;
    logic [1:0]         rr_ptr;     // first source to look at
    logic [1:0]         grant;
    logic [1:0]         sel;        // source whose message is going out
    logic [1:0]         idx;
    logic               found;
    logic               tag_wr;
    logic               val_wr;
    g_state             state_q;
    game_val_t          keeper_q;
    game_val_t          shot_q;
    game_val_t          score_q;

    // bit order matches the source numbering 0..3
    assign send_req = {score_send, shot_send, keeper_send, state_send};

    // round-robin search starting at rr_ptr
    always_comb begin
        grant = rr_ptr;
        found = 1'b0;
        idx   = rr_ptr;
        for (int i = 0; i < NUM_SRC; i++) begin
            idx = rr_ptr + 2'(i);
            if (!found && pending[idx]) begin
                grant = idx;
                found = 1'b1;
            end
        end
    end

    assign tag_wr = (phase == S_TAG) && found && !full;
    assign val_wr = (phase == S_VALUE) && !full;
    assign wr_en  = tag_wr || val_wr;

    always_comb begin
        if (phase == S_TAG) begin
            case (grant)
                2'd0:    wr_data = TAG_STATE;
                2'd1:    wr_data = TAG_KEEPER;
                2'd2:    wr_data = TAG_SHOT;
                default: wr_data = TAG_SCORE;
            endcase
        end else begin
            case (sel)
                2'd0:    wr_data = byte_t'(state_q);
                2'd1:    wr_data = keeper_q;
                2'd2:    wr_data = shot_q;
                default: wr_data = score_q;
            endcase
        end
    end

    // newest request overwrites the latched value
    always_ff @(posedge clk) begin
        if (state_send)  state_q  <= state_value;
        if (keeper_send) keeper_q <= keeper_value;
        if (shot_send)   shot_q   <= shot_value;
        if (score_send)  score_q  <= score_value;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= S_TAG;
            pending <= '0;
            rr_ptr  <= '0;
            sel     <= '0;
        end else begin
            for (int i = 0; i < NUM_SRC; i++) begin
                // a request in the value cycle keeps the flag set
                pending[i] <= send_req[i] || (pending[i] && !(val_wr && sel == 2'(i)));
            end
            if (tag_wr) begin
                sel   <= grant;
                phase <= S_VALUE;
            end
            if (val_wr) begin
                rr_ptr <= sel + 2'd1;   // next search starts after this one
                phase  <= S_TAG;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            empty,
    input  link_pkg::byte_t rd_data,
    output logic            rd_en,
    output logic            tx
);

    import link_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} tx_state_e;

    tx_state_e        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;
    logic             bit_done;

    assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // fetch in idle, or at the end of a stop bit for back to back frames
    assign rd_en = !empty && ((state == S_IDLE) || (state == S_STOP && bit_done));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            clk_cnt <= (bit_done || state == S_IDLE) ? '0 : clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    if (rd_en) begin
                        state <= S_START;
                        tx    <= 1'b0;
                    end
                end
                S_START: begin
                    if (clk_cnt == '0) shift_q <= rd_data;  // fifo data lands now
                    if (bit_done) begin
                        state   <= S_DATA;
                        bit_idx <= '0;
                        tx      <= shift_q[0];
                        shift_q <= shift_q >> 1;
                    end
                end
                S_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state <= S_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_q[0];   // lsb first
                            shift_q <= shift_q >> 1;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state <= rd_en ? S_START : S_IDLE;
                        tx    <= !rd_en;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    input  logic               full,
    output logic               wr_en,
    output link_pkg::rx_byte_t wr_data,
    output logic               overflow
);

    import link_pkg::*;

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP,
        S_WAIT_HIGH     // line stuck low after a bad stop bit
    } rx_state_e;

    rx_state_e        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    byte_t            shift_q;
    logic             bit_done;
    logic             mid_bit;

    assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign mid_bit  = (clk_cnt == CNT_W'(CLKS_PER_BIT / 2));

    // two flops, idle level is high
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            wr_en    <= 1'b0;
            overflow <= 1'b0;
        end else begin
            wr_en    <= 1'b0;
            overflow <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= S_START;
                end
                S_START: begin
                    if (mid_bit) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA;  // glitch, not a start
                    end
                end
                S_DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        shift_q <= {rx_sync, shift_q[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (bit_done) begin
                        clk_cnt           <= '0;
                        wr_data.data      <= shift_q;
                        wr_data.frame_err <= !rx_sync;
                        wr_en             <= !full;
                        overflow          <= full;     // byte is lost
                        state             <= rx_sync ? S_IDLE : S_WAIT_HIGH;
                    end
                end
                default: begin
                    clk_cnt <= '0;
                    if (rx_sync) state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/msg_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module msg_decoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                empty,
    input  link_pkg::rx_byte_t  rd_data,
    input  logic                overflow,
    output logic                rd_en,
    output game_pkg::g_state    enemy_state,
    output game_pkg::game_val_t enemy_keeper,
    output game_pkg::game_val_t enemy_shot,
    output game_pkg::game_val_t enemy_score,
    output logic                state_update,
    output logic                keeper_update,
    output logic                shot_update,
    output logic                score_update,
    output logic                link_error
);

    import game_pkg::*;
    import link_pkg::*;

    typedef enum logic {S_TAG, S_VALUE} dec_phase_e;

    dec_phase_e phase;
    msg_tag_e   cur_tag;    // tag waiting for its value
    logic       rd_valid;

    // drain whenever something is there
    assign rd_en = !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase         <= S_TAG;
            rd_valid      <= 1'b0;
            link_error    <= 1'b0;
            state_update  <= 1'b0;
            keeper_update <= 1'b0;
            shot_update   <= 1'b0;
            score_update  <= 1'b0;
            enemy_state   <= IDLE;
            enemy_keeper  <= '0;
            enemy_shot    <= '0;
            enemy_score   <= '0;
        end else begin
            rd_valid      <= rd_en;
            state_update  <= 1'b0;
            keeper_update <= 1'b0;
            shot_update   <= 1'b0;
            score_update  <= 1'b0;
            if (overflow) begin
                link_error <= 1'b1;    // sticky until reset
                phase      <= S_TAG;
            end else if (rd_valid) begin
                if (rd_data.frame_err) begin
                    link_error <= 1'b1;
                    phase      <= S_TAG;
                end else if (phase == S_TAG) begin
                    // unknown tags are skipped
                    if (is_known_tag(rd_data.data)) begin
                        cur_tag <= msg_tag_e'(rd_data.data);
                        phase   <= S_VALUE;
                    end
                end else begin
                    phase <= S_TAG;
                    case (cur_tag)
                        TAG_STATE: begin
                            enemy_state  <= g_state'(rd_data.data[2:0]);
                            state_update <= 1'b1;
                        end
                        TAG_KEEPER: begin
                            enemy_keeper  <= rd_data.data;
                            keeper_update <= 1'b1;
                        end
                        TAG_SHOT: begin
                            enemy_shot  <= rd_data.data;
                            shot_update <= 1'b1;
                        end
                        default: begin
                            enemy_score  <= rd_data.data;
                            score_update <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module link_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                state_send,
    input  game_pkg::g_state    state_value,
    input  logic                keeper_send,
    input  game_pkg::game_val_t keeper_value,
    input  logic                shot_send,
    input  game_pkg::game_val_t shot_value,
    input  logic                score_send,
    input  game_pkg::game_val_t score_value,
    input  logic                rx,
    output logic                tx,
    output game_pkg::g_state    enemy_state,
    output game_pkg::game_val_t enemy_keeper,
    output game_pkg::game_val_t enemy_shot,
    output game_pkg::game_val_t enemy_score,
    output logic                state_update,
    output logic                keeper_update,
    output logic                shot_update,
    output logic                score_update,
    output logic                link_error
);

    import link_pkg::*;

    // transmit path
    logic     tx_wr_en;
    byte_t    tx_wr_data;
    logic     tx_full;
    logic     tx_rd_en;
    byte_t    tx_rd_data;
    logic     tx_empty;

    // receive path
    logic     rx_wr_en;
    rx_byte_t rx_wr_data;
    logic     rx_full;
    logic     rx_rd_en;
    rx_byte_t rx_rd_data;
    logic     rx_empty;
    logic     rx_overflow;

    msg_encoder u_msg_encoder (
        .clk,
        .rst,
        .state_send,
        .state_value,
        .keeper_send,
        .keeper_value,
        .shot_send,
        .shot_value,
        .score_send,
        .score_value,
        .full    (tx_full),
        .wr_en   (tx_wr_en),
        .wr_data (tx_wr_data)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .item_t     (byte_t)
    ) tx_fifo (
        .clk,
        .rst,
        .wr_en   (tx_wr_en),
        .wr_data (tx_wr_data),
        .rd_en   (tx_rd_en),
        .rd_data (tx_rd_data),
        .full    (tx_full),
        .empty   (tx_empty)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk,
        .rst,
        .empty   (tx_empty),
        .rd_data (tx_rd_data),
        .rd_en   (tx_rd_en),
        .tx
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .clk,
        .rst,
        .rx,
        .full     (rx_full),
        .wr_en    (rx_wr_en),
        .wr_data  (rx_wr_data),
        .overflow (rx_overflow)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .item_t     (rx_byte_t)
    ) rx_fifo (
        .clk,
        .rst,
        .wr_en   (rx_wr_en),
        .wr_data (rx_wr_data),
        .rd_en   (rx_rd_en),
        .rd_data (rx_rd_data),
        .full    (rx_full),
        .empty   (rx_empty)
    );

    msg_decoder u_msg_decoder (
        .clk,
        .rst,
        .empty    (rx_empty),
        .rd_data  (rx_rd_data),
        .overflow (rx_overflow),
        .rd_en    (rx_rd_en),
        .enemy_state,
        .enemy_keeper,
        .enemy_shot,
        .enemy_score,
        .state_update,
        .keeper_update,
        .shot_update,
        .score_update,
        .link_error
    );

endmodule

`default_nettype wire

/* bench/link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module link_tb;

    import game_pkg::*;
    import link_pkg::*;

    localparam int BIT_CLKS    = 8;
    localparam int NUM_ENTRIES = 12;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 20 * BIT_CLKS * 2 + 2000;

    localparam int KIND_EVENT  = 0;     // through the encoder and tx loopback
    localparam int KIND_INJECT = 1;     // frames driven straight onto rx

    typedef struct packed {
        int        kind;
        int        src;                 // 0 state, 1 keeper, 2 shot, 3 score
        game_val_t value;
    } stim_t;

    logic      clk;
    logic      rst;
    logic      state_send;
    g_state    state_value;
    logic      keeper_send;
    game_val_t keeper_value;
    logic      shot_send;
    game_val_t shot_value;
    logic      score_send;
    game_val_t score_value;
    logic      rx;
    logic      tx;
    logic      rx_force;
    logic      rx_drv;
    g_state    enemy_state;
    game_val_t enemy_keeper;
    game_val_t enemy_shot;
    game_val_t enemy_score;
    logic      state_update;
    logic      keeper_update;
    logic      shot_update;
    logic      score_update;
    logic      link_error;

    stim_t       stim [NUM_ENTRIES];
    msg_tag_e    tag_log [$];
    game_val_t   val_log [$];
    int          log_base;
    int          cycle_cnt;
    logic [31:0] rng;

    // loopback unless the bench takes over the line
    assign rx = rx_force ? rx_drv : tx;

    link_top #(
        .CLKS_PER_BIT (BIT_CLKS),
        .FIFO_DEPTH   (16)
    ) link_top_inst (
        .clk,
        .rst,
        .state_send,
        .state_value,
        .keeper_send,
        .keeper_value,
        .shot_send,
        .shot_value,
        .score_send,
        .score_value,
        .rx,
        .tx,
        .enemy_state,
        .enemy_keeper,
        .enemy_shot,
        .enemy_score,
        .state_update,
        .keeper_update,
        .shot_update,
        .score_update,
        .link_error
    );

    always #10 clk = ~clk;

    // every update pulse in arrival order
    always @(posedge clk) begin
        if (!rst) begin
            if (state_update) begin
                tag_log.push_back(TAG_STATE);
                val_log.push_back(game_val_t'(enemy_state));
            end
            if (keeper_update) begin
                tag_log.push_back(TAG_KEEPER);
                val_log.push_back(enemy_keeper);
            end
            if (shot_update) begin
                tag_log.push_back(TAG_SHOT);
                val_log.push_back(enemy_shot);
            end
            if (score_update) begin
                tag_log.push_back(TAG_SCORE);
                val_log.push_back(enemy_score);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout waiting for update pulse");
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_state(input string name, input g_state exp, input g_state act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_value(input string name, input game_val_t exp, input game_val_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %02h, actual %02h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_tag(input string name, input msg_tag_e exp, input msg_tag_e act);
        if (act !== exp) begin
            $display("mismatch %s: expected tag %02h, actual tag %02h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0b, actual %0b", name, exp, act);
            fail_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_value(output game_val_t v);
        rng = xorshift32(rng);
        v   = rng[7:0];
    endtask

    function automatic msg_tag_e tag_of(input int src);
        case (src)
            0:       return TAG_STATE;
            1:       return TAG_KEEPER;
            2:       return TAG_SHOT;
            default: return TAG_SCORE;
        endcase
    endfunction

    function automatic logic has_entry(input msg_tag_e t, input game_val_t v);
        for (int k = log_base; k < tag_log.size(); k++) begin
            if (tag_log[k] == t && val_log[k] == v) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic build_table();
        game_val_t v;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            next_value(v);
            stim[i].kind  = (i % 3 == 2) ? KIND_INJECT : KIND_EVENT;
            stim[i].src   = i % 4;
            stim[i].value = (i % 4 == 0) ? game_val_t'(v % 5) : v;  // legal state codes only
        end
    endtask

    task automatic drive_request(input int src, input game_val_t v);
        case (src)
            0: begin
                state_send  <= 1'b1;
                state_value <= g_state'(v[2:0]);
            end
            1: begin
                keeper_send  <= 1'b1;
                keeper_value <= v;
            end
            2: begin
                shot_send  <= 1'b1;
                shot_value <= v;
            end
            default: begin
                score_send  <= 1'b1;
                score_value <= v;
            end
        endcase
    endtask

    task automatic clear_requests();
        state_send  <= 1'b0;
        keeper_send <= 1'b0;
        shot_send   <= 1'b0;
        score_send  <= 1'b0;
    endtask

    task automatic send_event(input int src, input game_val_t v);
        @(posedge clk);
        drive_request(src, v);
        @(posedge clk);
        clear_requests();
    endtask

    task automatic drive_bit(input logic b);
        rx_drv <= b;
        repeat (BIT_CLKS) @(posedge clk);
    endtask

    // 8N1 frame with a chosen stop level and two idle bits after it
    task automatic inject_frame(input byte_t b, input logic stop_bit);
        @(posedge clk);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);    // lsb first
        end
        drive_bit(stop_bit);
        drive_bit(1'b1);
        drive_bit(1'b1);
    endtask

    task automatic inject_message(input byte_t tag, input game_val_t v);
        inject_frame(tag, 1'b1);
        inject_frame(v, 1'b1);
    endtask

    task automatic mark_log();
        log_base = tag_log.size();
    endtask

    task automatic wait_updates(input int n);
        while (tag_log.size() < log_base + n) @(posedge clk);
    endtask

    // k counts from the last mark
    task automatic check_entry(input string name, input int k, input int src,
                               input game_val_t exp);
        check_tag(name, tag_of(src), tag_log[log_base + k]);
        if (src == 0) begin
            check_state(name, g_state'(exp[2:0]), g_state'(val_log[log_base + k][2:0]));
        end else begin
            check_value(name, exp, val_log[log_base + k]);
        end
    endtask

    task automatic check_register(input string name, input int src, input game_val_t exp);
        case (src)
            0:       check_state(name, g_state'(exp[2:0]), enemy_state);
            1:       check_value(name, exp, enemy_keeper);
            2:       check_value(name, exp, enemy_shot);
            default: check_value(name, exp, enemy_score);
        endcase
    endtask

    initial begin
        game_val_t v [4];
        game_val_t k1;
        game_val_t k2;
        game_val_t k3;
        game_val_t last_keeper;
        logic      seen_last;
        logic      stale;
        string     name;

        clk          = 1'b0;
        rst          = 1'b1;
        state_send   = 1'b0;
        state_value  = IDLE;
        keeper_send  = 1'b0;
        keeper_value = '0;
        shot_send    = 1'b0;
        shot_value   = '0;
        score_send   = 1'b0;
        score_value  = '0;
        rx_force     = 1'b1;    // rx held high until tx leaves reset
        rx_drv       = 1'b1;
        cycle_cnt    = 0;
        log_base     = 0;
        rng          = 32'd67110;
        build_table();

        repeat (8) @(posedge clk);
        check_flag("tx idle after reset", 1'b1, tx);
        rst      <= 1'b0;
        rx_force <= 1'b0;

        // all four sources in the same cycle with the pointer at state
        for (int s = 0; s < 4; s++) begin
            next_value(v[s]);
        end
        v[0] = game_val_t'(v[0] % 5);
        mark_log();
        @(posedge clk);
        for (int s = 0; s < 4; s++) begin
            drive_request(s, v[s]);
        end
        @(posedge clk);
        clear_requests();
        wait_updates(4);
        for (int s = 0; s < 4; s++) begin
            check_entry($sformatf("round robin %0d", s), s, s, v[s]);
        end

        foreach (stim[i]) begin
            name = $sformatf("entry %0d", i);
            mark_log();
            if (stim[i].kind == KIND_EVENT) begin
                send_event(stim[i].src, stim[i].value);
            end else begin
                rx_force <= 1'b1;
                inject_message(tag_of(stim[i].src), stim[i].value);
                rx_force <= 1'b0;
            end
            wait_updates(1);
            check_entry(name, 0, stim[i].src, stim[i].value);
            check_register(name, stim[i].src, stim[i].value);
        end

        // keeper requests pile up behind three other messages
        for (int s = 0; s < 4; s++) begin
            next_value(v[s]);
        end
        v[0] = game_val_t'(v[0] % 5);
        next_value(k1);
        k2 = k1 + 8'd1;
        k3 = k1 + 8'd2;
        mark_log();
        @(posedge clk);
        drive_request(0, v[0]);
        drive_request(2, v[2]);
        drive_request(3, v[3]);
        @(posedge clk);
        clear_requests();
        send_event(1, k1);
        send_event(1, k2);
        send_event(1, k3);
        while (!has_entry(TAG_KEEPER, k3)) @(posedge clk);
        repeat (2 * 10 * BIT_CLKS + 20) @(posedge clk);  // room for one more message
        seen_last   = 1'b0;
        stale       = 1'b0;
        last_keeper = '0;
        for (int k = log_base; k < tag_log.size(); k++) begin
            if (tag_log[k] == TAG_KEEPER) begin
                if (seen_last) stale = 1'b1;
                if (val_log[k] == k3) seen_last = 1'b1;
                last_keeper = val_log[k];
            end
        end
        check_value("coalesce last keeper", k3, last_keeper);
        check_flag("coalesce keeper after last request", 1'b0, stale);
        check_value("coalesce shot", v[2], enemy_shot);
        check_value("coalesce score", v[3], enemy_score);

        // unknown tag byte ahead of a full keeper message
        next_value(k1);
        mark_log();
        rx_force <= 1'b1;
        inject_frame(8'h55, 1'b1);
        inject_message(TAG_KEEPER, k1);
        rx_force <= 1'b0;
        wait_updates(1);
        check_entry("unknown tag", 0, 1, k1);
        check_flag("unknown tag single update", 1'b1, tag_log.size() == log_base + 1);
        check_flag("unknown tag link_error", 1'b0, link_error);

        // shot tag with a low stop bit and a value byte below the tag range
        next_value(k1);
        next_value(k2);
        mark_log();
        rx_force <= 1'b1;
        inject_frame(TAG_SHOT, 1'b0);
        inject_frame(k1 & 8'h7f, 1'b1);
        rx_force <= 1'b0;
        check_flag("framing link_error", 1'b1, link_error);
        check_flag("framing no update", 1'b1, tag_log.size() == log_base);
        send_event(3, k2);
        wait_updates(1);
        check_entry("score after framing error", 0, 3, k2);
        check_flag("link_error stays set", 1'b1, link_error);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/game_pkg.sv
source/link_pkg.sv
source/byte_fifo.sv
source/msg_encoder.sv
source/uart_tx.sv
source/uart_rx.sv
source/msg_decoder.sv
source/link_top.sv
bench/link_tb.sv

/* Bender.yml */
package:
  name: penalty_link

sources:
  - source/game_pkg.sv
  - source/link_pkg.sv
  - source/byte_fifo.sv
  - source/msg_encoder.sv
  - source/uart_tx.sv
  - source/uart_rx.sv
  - source/msg_decoder.sv
  - source/link_top.sv
  - target: simulation
    files:
      - bench/link_tb.sv
